// File: rtl/mm_pkg.sv
// shared types for the memory subsystem
// data port request and response structs, peripheral address map, status code

package mm_pkg;

    // one data port request as issued by the master
    typedef struct packed {
        logic [31:0] addr;
        logic        we;
        logic [3:0]  be;
        logic [31:0] wdata;
    } data_req_t;

    // one data port response, valid one cycle after the grant
    typedef struct packed {
        logic        rvalid;
        logic [31:0] rdata;
    } data_rsp_t;

    // peripheral region, selected by the top nibble of the data address
    localparam logic [31:0] PERIPH_BASE = 32'h1000_0000;

    // word offsets of the peripheral registers inside the region
    localparam logic [31:0] STATUS_OFFSET      = 32'h0000_0000;
    localparam logic [31:0] TIMER_LOAD_OFFSET  = 32'h0000_0004;
    localparam logic [31:0] TIMER_COUNT_OFFSET = 32'h0000_0008;

    // status code that marks a passing test, any other nonzero code is a failure
    localparam logic [31:0] STATUS_PASS = 32'h600D_C0DE;

endpackage

// File: rtl/ram_bank.sv
// word-organized RAM for the test harness
// wide instruction fetch port and a byte-enabled 32-bit data port

module ram_bank #(
    parameter int RAM_ADDR_WIDTH    = 12,
    parameter int INSTR_RDATA_WIDTH = 128
) (
    input  logic                         clk_i,
    input  logic                         rst_i,

    input  logic                         instr_req_i,
    input  logic [RAM_ADDR_WIDTH-1:0]    instr_addr_i,
    output logic [INSTR_RDATA_WIDTH-1:0] instr_rdata_o,
    output logic                         instr_rvalid_o,

    input  logic                         data_req_i,
    input  mm_pkg::data_req_t            data_req_s_i,
    output logic [31:0]                  data_rdata_o
);

    localparam int WORD_AW    = RAM_ADDR_WIDTH - 2;
    localparam int WORDS      = 2 ** WORD_AW;
    localparam int LINE_WORDS = INSTR_RDATA_WIDTH / 32;

    logic [31:0]        mem [WORDS];
    logic [WORD_AW-1:0] data_word;
    logic [WORD_AW-1:0] instr_line_base;

    // only the low address bits reach the RAM, so larger addresses wrap
    assign data_word = data_req_s_i.addr[RAM_ADDR_WIDTH-1:2];

    // first word of the fetch line, aligned to the line size
    assign instr_line_base = instr_addr_i[RAM_ADDR_WIDTH-1:2] & ~WORD_AW'(LINE_WORDS - 1);

    // data port, stores update only the enabled bytes
    always_ff @(posedge clk_i) begin
        if (data_req_i && data_req_s_i.we) begin
            for (int b = 0; b < 4; b++) begin
                if (data_req_s_i.be[b]) begin
                    mem[data_word][8*b +: 8] <= data_req_s_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // load data is registered, a load right after a store sees the new word
    always_ff @(posedge clk_i) begin
        if (data_req_i && !data_req_s_i.we) begin
            data_rdata_o <= mem[data_word];
        end
    end

    // instruction line read, a store in the same cycle is not visible yet
    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                instr_rdata_o[32*w +: 32] <= mem[instr_line_base | WORD_AW'(w)];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            instr_rvalid_o <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
        end
    end

endmodule

// File: rtl/mm_periph.sv
// memory-mapped pseudo peripherals
// sticky test status flags and a down-counting timer with a level interrupt

module mm_periph (
    input  logic              clk_i,
    input  logic              rst_i,

    input  logic              periph_req_i,
    input  mm_pkg::data_req_t periph_req_s_i,
    output logic [31:0]       periph_rdata_o,

    input  logic              irq_ack_i,
    output logic              irq_o,

    output logic              tests_passed_o,
    output logic              tests_failed_o
);

    import mm_pkg::*;

    logic [25:0] word_off;
    logic        wr_en;
    logic        rd_en;
    logic        sel_status;
    logic        sel_load;
    logic        sel_count;
    logic        load_timer;
    logic        expire;
    logic [31:0] count_q;

    // registers are decoded on the word offset inside the peripheral region
    assign word_off   = periph_req_s_i.addr[27:2];
    assign sel_status = word_off == STATUS_OFFSET[27:2];
    assign sel_load   = word_off == TIMER_LOAD_OFFSET[27:2];
    assign sel_count  = word_off == TIMER_COUNT_OFFSET[27:2];

    assign wr_en = periph_req_i && periph_req_s_i.we;
    assign rd_en = periph_req_i && !periph_req_s_i.we;

    assign load_timer = wr_en && sel_load;
    // the counter reaches zero on this edge
    assign expire     = !load_timer && (count_q == 32'd1);

    // status flags stay set until reset, a zero write leaves them alone
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
        end else if (wr_en && sel_status && (periph_req_s_i.wdata != '0)) begin
            if (periph_req_s_i.wdata == STATUS_PASS) begin
                tests_passed_o <= 1'b1;
            end else begin
                tests_failed_o <= 1'b1;
            end
        end
    end

    // timer counts down once per cycle and idles at zero
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (load_timer) begin
            count_q <= periph_req_s_i.wdata;
        end else if (count_q != '0) begin
            count_q <= count_q - 32'd1;
        end
    end

    // a new expiry takes precedence over an acknowledge in the same cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            irq_o <= 1'b0;
        end else if (expire) begin
            irq_o <= 1'b1;
        end else if (irq_ack_i) begin
            irq_o <= 1'b0;
        end
    end

    // only the counter is readable; status, load and unmapped offsets read zero
    always_ff @(posedge clk_i) begin
        periph_rdata_o <= (rd_en && sel_count) ? count_q : '0;
    end

endmodule

// File: rtl/data_router.sv
// data port router
// decodes each request to RAM or peripherals and returns the matching response

module data_router (
    input  logic              clk_i,
    input  logic              rst_i,

    input  logic              data_req_i,
    input  mm_pkg::data_req_t data_req_s_i,
    output logic              data_gnt_o,

    output logic              ram_req_o,
    output logic              periph_req_o,
    input  logic [31:0]       ram_rdata_i,
    input  logic [31:0]       periph_rdata_i,

    output mm_pkg::data_rsp_t data_rsp_o
);

    import mm_pkg::*;

    logic to_periph;
    logic pend_q;
    logic periph_q;
    logic store_q;

    // the top nibble selects the peripheral region, everything else is RAM
    assign to_periph = data_req_s_i.addr[31:28] == PERIPH_BASE[31:28];

    // no back-pressure, every request is granted at once
    assign data_gnt_o   = data_req_i;
    assign ram_req_o    = data_req_i && !to_periph;
    assign periph_req_o = data_req_i && to_periph;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pend_q   <= 1'b0;
            periph_q <= 1'b0;
            store_q  <= 1'b0;
        end else begin
            pend_q   <= data_req_i;
            periph_q <= to_periph;
            store_q  <= data_req_s_i.we;
        end
    end

    assign data_rsp_o.rvalid = pend_q;

    // stores answer with zero data
    always_comb begin
        if (!pend_q || store_q) begin
            data_rsp_o.rdata = '0;
        end else if (periph_q) begin
            data_rsp_o.rdata = periph_rdata_i;
        end else begin
            data_rsp_o.rdata = ram_rdata_i;
        end
    end

endmodule

// File: rtl/mem_wrapper.sv
// top level of the memory subsystem
// RAM, pseudo peripherals and the data router behind one instruction and one data port

module mem_wrapper #(
    parameter int RAM_ADDR_WIDTH    = 12,
    parameter int INSTR_RDATA_WIDTH = 128
) (
    input  logic                         clk_i,
    input  logic                         rst_i,

    input  logic                         instr_req_i,
    input  logic [RAM_ADDR_WIDTH-1:0]    instr_addr_i,
    output logic                         instr_gnt_o,
    output logic                         instr_rvalid_o,
    output logic [INSTR_RDATA_WIDTH-1:0] instr_rdata_o,

    input  logic                         data_req_i,
    input  mm_pkg::data_req_t            data_req_s_i,
    output logic                         data_gnt_o,
    output mm_pkg::data_rsp_t            data_rsp_o,

    input  logic                         irq_ack_i,
    output logic                         irq_o,

    output logic                         tests_passed_o,
    output logic                         tests_failed_o
);

    logic        ram_req;
    logic        periph_req;
    logic [31:0] ram_rdata;
    logic [31:0] periph_rdata;

    // instruction fetches are always accepted in the cycle they are made
    assign instr_gnt_o = instr_req_i;

    data_router data_router_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .data_req_i     (data_req_i),
        .data_req_s_i   (data_req_s_i),
        .data_gnt_o     (data_gnt_o),
        .ram_req_o      (ram_req),
        .periph_req_o   (periph_req),
        .ram_rdata_i    (ram_rdata),
        .periph_rdata_i (periph_rdata),
        .data_rsp_o     (data_rsp_o)
    );

    ram_bank #(
        .RAM_ADDR_WIDTH    (RAM_ADDR_WIDTH),
        .INSTR_RDATA_WIDTH (INSTR_RDATA_WIDTH)
    ) ram_bank_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_rdata_o  (instr_rdata_o),
        .instr_rvalid_o (instr_rvalid_o),
        .data_req_i     (ram_req),
        .data_req_s_i   (data_req_s_i),
        .data_rdata_o   (ram_rdata)
    );

    // both targets see the same request, the strobe decides who acts
    mm_periph mm_periph_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .periph_req_i   (periph_req),
        .periph_req_s_i (data_req_s_i),
        .periph_rdata_o (periph_rdata),
        .irq_ack_i      (irq_ack_i),
        .irq_o          (irq_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o)
    );

endmodule

// File: tests/tb_clock.sv
// clock and reset generator for the testbench
// 10 ns clock, reset held for 3 rising edges at start and on request

module tb_clock (
    output logic clk_o,
    output logic rst_o,
    input  logic rst_req_i
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever begin
            #5 clk_o = ~clk_o;
        end
    end

    // reset drops 1 ns after its third rising edge, like any other input
    initial begin
        rst_o = 1'b1;
        forever begin
            repeat (3) @(posedge clk_o);
            #1;
            rst_o = 1'b0;
            @(posedge rst_req_i);
            rst_o = 1'b1;
        end
    end

endmodule

// File: tests/tb_mem_wrapper.sv
// testbench top for the memory subsystem
// random data and fetch traffic, timer and status checks against a reference model

module tb_mem_wrapper;

    timeunit 1ns;
    timeprecision 1ps;

    import mm_pkg::*;

    localparam int AW    = 12;
    localparam int IW    = 128;
    localparam int WORDS = 2 ** (AW - 2);

    // expected response and the clock edge count at which its rvalid is due
    typedef struct packed {
        logic [31:0]   due;
        logic [IW-1:0] data;
    } exp_t;

    logic          clk_i;
    logic          rst_i;
    logic          rst_req = 1'b0;
    logic          instr_req_i = 1'b0;
    logic [AW-1:0] instr_addr_i = '0;
    logic          instr_gnt_o;
    logic          instr_rvalid_o;
    logic [IW-1:0] instr_rdata_o;
    logic          data_req_i = 1'b0;
    data_req_t     data_req_s_i = '0;
    logic          data_gnt_o;
    data_rsp_t     data_rsp_o;
    logic          irq_ack_i = 1'b0;
    logic          irq_o;
    logic          tests_passed_o;
    logic          tests_failed_o;

    logic [31:0]   model_mem [WORDS];
    logic [31:0]   timer_val = '0;
    logic [31:0]   timer_grant = '0;
    logic [31:0]   rng = 32'd14;
    logic [31:0]   cycle_cnt = '0;
    exp_t          data_q [$];
    exp_t          instr_q [$];

    tb_clock tb_clock_inst (
        .clk_o     (clk_i),
        .rst_o     (rst_i),
        .rst_req_i (rst_req)
    );

    mem_wrapper #(
        .RAM_ADDR_WIDTH    (AW),
        .INSTR_RDATA_WIDTH (IW)
    ) mem_wrapper_inst (.*);

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // expected rdata of a data request granted at the given edge
    // stores also update the model memory and the model timer
    function automatic logic [31:0] ref_data(input data_req_t req, input logic [31:0] grant);
        logic [31:0] elapsed;
        if (req.addr[31:28] == PERIPH_BASE[31:28]) begin
            if (req.we && req.addr[27:2] == TIMER_LOAD_OFFSET[27:2]) begin
                timer_val   = req.wdata;
                timer_grant = grant;
            end
            // the counter reads back the value it held just before the grant edge
            elapsed = grant - timer_grant - 1;
            if (req.we || req.addr[27:2] != TIMER_COUNT_OFFSET[27:2] || elapsed >= timer_val) begin
                return '0;
            end
            return timer_val - elapsed;
        end
        if (!req.we) begin
            return model_mem[req.addr[AW-1:2]];
        end
        for (int b = 0; b < 4; b++) begin
            if (req.be[b]) begin
                model_mem[req.addr[AW-1:2]][8*b +: 8] = req.wdata[8*b +: 8];
            end
        end
        return '0;
    endfunction

    // expected fetch line, the words of the IW/8 byte block that holds the address
    function automatic logic [IW-1:0] ref_line(input logic [AW-1:0] addr);
        logic [IW-1:0] line;
        int            first;
        first = (int'(addr) / (IW / 8)) * (IW / 32);
        for (int i = 0; i < IW / 32; i++) begin
            line[32*i +: 32] = model_mem[first + i];
        end
        return line;
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check(input logic ok, input string what);
        assert (ok) else begin
            stop_run($sformatf("[FAIL] time %0d ns: %s", $time, what));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
        data_req_i  = 1'b0;
        instr_req_i = 1'b0;
        irq_ack_i   = 1'b0;
    endtask

    // drive a data request for this cycle and queue its expected response
    task automatic drive_data(input logic [31:0] addr, input logic we,
                              input logic [3:0] be, input logic [31:0] wdata);
        exp_t e;
        data_req_i         = 1'b1;
        data_req_s_i.addr  = addr;
        data_req_s_i.we    = we;
        data_req_s_i.be    = be;
        data_req_s_i.wdata = wdata;
        e.due  = cycle_cnt + 1;
        e.data = IW'(ref_data(data_req_s_i, e.due));
        data_q.push_back(e);
    endtask

    // the expected line is taken before any store of the same cycle reaches the model
    task automatic drive_instr(input logic [AW-1:0] addr);
        exp_t e;
        e.data       = ref_line(addr);
        e.due        = cycle_cnt + 1;
        instr_req_i  = 1'b1;
        instr_addr_i = addr;
        instr_q.push_back(e);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (data_q.size() != 0 || instr_q.size() != 0) begin
            next_cycle();
            n++;
            if (n > 20) stop_run("timeout waiting for outstanding responses");
        end
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        @(negedge clk_i);
        while (rst_i) begin
            @(negedge clk_i);
            n++;
            if (n > 20) stop_run("timeout waiting for reset to be released");
        end
    endtask

    // responses are compared at the falling edge, half a cycle from the drive point
    always @(negedge clk_i) begin : compare_responses
        exp_t e;
        if (!rst_i) begin
            check(data_gnt_o == data_req_i && instr_gnt_o == instr_req_i,
                  "grant differs from request");
            if (data_q.size() != 0 && data_q[0].due == cycle_cnt) begin
                e = data_q.pop_front();
                check(data_rsp_o.rvalid && data_rsp_o.rdata == e.data[31:0],
                      $sformatf("data rdata %h, expected %h", data_rsp_o.rdata, e.data[31:0]));
            end else begin
                check(!data_rsp_o.rvalid, "data rvalid without a granted request");
            end
            if (instr_q.size() != 0 && instr_q[0].due == cycle_cnt) begin
                e = instr_q.pop_front();
                check(instr_rvalid_o && instr_rdata_o == e.data,
                      $sformatf("fetch line %h, expected %h", instr_rdata_o, e.data));
            end else begin
                check(!instr_rvalid_o, "instr rvalid without a granted fetch");
            end
        end
    end

    initial begin : stimulus
        logic [31:0]   r;
        logic [31:0]   addr;
        logic [AW-1:0] a;
        logic [31:0]   load_grant;
        int            n;
        wait_reset();
        repeat (4) begin
            next_cycle();
            check(!irq_o && !tests_passed_o && !tests_failed_o, "control output high after reset");
        end
        // full-word fill carrying the word index, so every load and fetch has a known value
        for (int w = 0; w < WORDS; w++) begin
            drive_data(32'(w) << 2, 1'b1, 4'hF, {6'h2A, (AW-2)'(w), 6'h15, (AW-2)'(w)});
            next_cycle();
        end
        // byte-enabled stores each followed at once by a load, upper address bits wrap
        repeat (200) begin
            addr = next_rand() & 32'hEFFF_FFFC;
            r    = next_rand();
            drive_data(addr, 1'b1, r[3:0], next_rand());
            next_cycle();
            drive_data(addr, 1'b0, 4'hF, '0);
            next_cycle();
        end
        repeat (40) begin
            r = next_rand();
            drive_instr(r[AW-1:0]);
            next_cycle();
        end
        // a fetch racing a store to the same word sees the old word, the next fetch the new
        repeat (8) begin
            r = next_rand();
            a = {r[AW-1:2], 2'b00};
            drive_instr(a);
            drive_data(32'(a), 1'b1, 4'hF, ~model_mem[a[AW-1:2]]);
            next_cycle();
            drive_instr(a);
            next_cycle();
        end
        wait_idle();
        drive_data(PERIPH_BASE | TIMER_LOAD_OFFSET, 1'b1, 4'hF, 32'd6);
        load_grant = cycle_cnt + 1;
        repeat (2) begin
            next_cycle();
            drive_data(PERIPH_BASE | TIMER_COUNT_OFFSET, 1'b0, 4'hF, '0);
        end
        n = 0;
        while (!irq_o) begin
            next_cycle();
            n++;
            if (n > 50) stop_run("timeout waiting for the timer interrupt");
        end
        check(cycle_cnt == load_grant + 6, "interrupt did not rise 6 cycles after the load");
        next_cycle();
        check(irq_o, "interrupt dropped without an acknowledge");
        irq_ack_i = 1'b1;
        next_cycle();
        check(!irq_o, "interrupt still high after the acknowledge");
        drive_data(PERIPH_BASE | STATUS_OFFSET, 1'b1, 4'hF, 32'hBAD0_0001);
        next_cycle();
        check(tests_failed_o && !tests_passed_o, "fail code did not set only the fail flag");
        drive_data(PERIPH_BASE | STATUS_OFFSET, 1'b0, 4'hF, '0);
        next_cycle();
        wait_idle();
        rst_req = 1'b1;
        next_cycle();
        rst_req = 1'b0;
        wait_reset();
        next_cycle();
        check(!tests_failed_o && !tests_passed_o, "reset did not clear the status flags");
        drive_data(PERIPH_BASE | STATUS_OFFSET, 1'b1, 4'hF, STATUS_PASS);
        next_cycle();
        check(tests_passed_o && !tests_failed_o, "pass code did not set only the pass flag");
        wait_idle();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: compile.f
rtl/mm_pkg.sv
rtl/ram_bank.sv
rtl/mm_periph.sv
rtl/data_router.sv
rtl/mem_wrapper.sv
tests/tb_clock.sv
tests/tb_mem_wrapper.sv

// File: Makefile
TOP := tb_mem_wrapper
RTL := $(filter rtl/%.sv,$(shell cat compile.f))

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f $(shell cat compile.f)
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --top-module mem_wrapper $(RTL)

clean:
	rm -rf obj_dir
